// ==== verilog/wr_ic_pkg.sv ====
// channel count, burst and address constants, vector types, scheduler state enum
package wr_ic_pkg;

    localparam int NUM_CH     = 5;       // image channels
    localparam int BURST_LEN  = 16;      // beats per burst
    localparam int ADDR_STEP  = 128;     // address advance per burst
    localparam int FRAME_SPAN = 30000;   // ping-pong bank distance
    localparam int CH_SPAN    = 60000;   // channel region distance
    localparam int INIT_CH    = 3;       // channel that raises init_done

    // ddr controller address is row, bank, column
    localparam int ROW_W      = 15;
    localparam int BANK_W     = 3;
    localparam int COL_W      = 10;
    localparam int DDR_ADDR_W = ROW_W + BANK_W + COL_W;

    localparam int DATA_W     = 256;     // one axi beat
    localparam int BUF_ADDR_W = 5;       // two bursts deep
    localparam int CH_IDX_W   = 3;
    localparam int BEAT_CNT_W = 4;

    typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;

    typedef logic [DATA_W-1:0]     axi_data_t;

    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    typedef logic [CH_IDX_W-1:0]   ch_idx_t;

    typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

    typedef enum logic {
        sched_wait,                      // waiting for current channel buffer
        sched_busy                       // burst in flight
    } sched_state_t;

endpackage

// ==== verilog/wr_channel_sched.sv ====
// round-robin channel scheduler, one burst in flight at a time
module wr_channel_sched
    import wr_ic_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    buf_ready [NUM_CH],
    input  logic    burst_done,
    output logic    start,
    output ch_idx_t cur_ch
);

    sched_state_t state;
    ch_idx_t      next_ch;

    // fixed visiting order, wraps after the last channel
    always_comb begin
        if (cur_ch == ch_idx_t'(NUM_CH - 1)) begin
            next_ch = '0;
        end else begin
            next_ch = cur_ch + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= sched_wait;
            start  <= 1'b0;
            cur_ch <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                sched_wait: begin
                    if (buf_ready[cur_ch]) begin   // stay on this channel until ready
                        start <= 1'b1;
                        state <= sched_busy;
                    end
                end
                sched_busy: begin
                    if (burst_done) begin
                        cur_ch <= next_ch;
                        state  <= sched_wait;
                    end
                end
                default: begin
                    state <= sched_wait;
                end
            endcase
        end
    end

endmodule

// ==== verilog/wr_addr_gen.sv ====
// per-channel ping-pong frame address generator and axi write address stage
module wr_addr_gen
    import wr_ic_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  ch_idx_t   cur_ch,
    input  logic      frame_end [NUM_CH],
    output ddr_addr_t axi_awaddr,
    output logic      axi_awvalid,
    input  logic      axi_awready,
    output logic      aw_accept,
    output ch_idx_t   burst_ch,
    output logic      init_done
);

    ddr_addr_t ch_offset [NUM_CH];   // grows by one burst step per address
    logic      ch_bank   [NUM_CH];   // frame half in use
    ddr_addr_t ch_base;
    ddr_addr_t bank_add;
    ddr_addr_t next_addr;
    logic      aw_hs;

    assign aw_hs = axi_awvalid && axi_awready;

    // channel region base plus bank and running offset
    always_comb begin
        ch_base = ddr_addr_t'(cur_ch) * ddr_addr_t'(CH_SPAN);
        if (ch_bank[cur_ch]) begin
            bank_add = ddr_addr_t'(FRAME_SPAN);
        end else begin
            bank_add = '0;
        end
        next_addr = ch_base + bank_add + ch_offset[cur_ch];
    end

    always_ff @(posedge clk) begin
        if (start) begin
            axi_awaddr <= next_addr;   // held until the handshake
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            axi_awvalid <= 1'b0;
            aw_accept   <= 1'b0;
            burst_ch    <= '0;
        end else begin
            aw_accept <= aw_hs;
            if (start) begin
                axi_awvalid <= 1'b1;
                burst_ch    <= cur_ch;
            end else if (aw_hs) begin
                axi_awvalid <= 1'b0;
            end
        end
    end

    // frame end beats the offset advance on the same edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                ch_offset[c] <= '0;
                ch_bank[c]   <= 1'b0;
            end
        end else begin
            for (int c = 0; c < NUM_CH; c++) begin
                if (frame_end[c]) begin
                    ch_offset[c] <= '0;
                    ch_bank[c]   <= ~ch_bank[c];
                end else if (aw_hs && (burst_ch == ch_idx_t'(c))) begin
                    ch_offset[c] <= ch_offset[c] + ddr_addr_t'(ADDR_STEP);
                end
            end
        end
    end

    // sticky once the init channel has closed a frame
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            init_done <= 1'b0;
        end else if (frame_end[INIT_CH]) begin
            init_done <= 1'b1;
        end
    end

endmodule

// ==== verilog/wr_burst_mover.sv ====
// burst data stage, buffer read pointers and axi write data channel
module wr_burst_mover
    import wr_ic_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      aw_accept,
    input  ch_idx_t   burst_ch,
    input  axi_data_t buf_data [NUM_CH],
    output buf_addr_t buf_addr [NUM_CH],
    output axi_data_t axi_wdata,
    output logic      axi_wvalid,
    input  logic      axi_wready,
    output logic      axi_wlast,
    output logic      burst_done
);

    ch_idx_t   act_ch;      // channel of the burst in flight
    beat_cnt_t beat_cnt;
    logic      w_hs;
    logic      last_beat;

    assign w_hs      = axi_wvalid && axi_wready;
    assign last_beat = (beat_cnt == beat_cnt_t'(BURST_LEN - 1));

    // zero latency buffers so data follows buf_addr directly
    assign axi_wdata = buf_data[act_ch];
    assign axi_wlast = last_beat;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            act_ch     <= '0;
            beat_cnt   <= '0;
            axi_wvalid <= 1'b0;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            if (aw_accept) begin
                act_ch     <= burst_ch;
                beat_cnt   <= '0;
                axi_wvalid <= 1'b1;
            end else if (w_hs) begin
                beat_cnt <= beat_cnt + 1'b1;   // wraps to zero after the last beat
                if (last_beat) begin
                    axi_wvalid <= 1'b0;
                    burst_done <= 1'b1;
                end
            end
        end
    end

    // read pointer steps once per accepted beat
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                buf_addr[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NUM_CH; c++) begin
                if (w_hs && (act_ch == ch_idx_t'(c))) begin
                    buf_addr[c] <= buf_addr[c] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/frame_wr_interconnect.sv ====
// top level of the frame write interconnect, scheduler, address and data stages
module frame_wr_interconnect
    import wr_ic_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // channel line buffers
    input  logic      buf_ready [NUM_CH],
    input  axi_data_t buf_data  [NUM_CH],
    output buf_addr_t buf_addr  [NUM_CH],
    input  logic      frame_end [NUM_CH],
    output logic      init_done,
    // axi write address channel
    output ddr_addr_t axi_awaddr,
    output logic      axi_awvalid,
    input  logic      axi_awready,
    // axi write data channel
    output axi_data_t axi_wdata,
    output logic      axi_wvalid,
    input  logic      axi_wready,
    output logic      axi_wlast
);

    logic    start;
    ch_idx_t cur_ch;
    logic    aw_accept;
    ch_idx_t burst_ch;
    logic    burst_done;

    wr_channel_sched u_sched (
        .clk        (clk),
        .rst        (rst),
        .buf_ready  (buf_ready),
        .burst_done (burst_done),
        .start      (start),
        .cur_ch     (cur_ch)
    );

    wr_addr_gen u_addr_gen (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cur_ch      (cur_ch),
        .frame_end   (frame_end),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .aw_accept   (aw_accept),
        .burst_ch    (burst_ch),
        .init_done   (init_done)
    );

    wr_burst_mover u_burst_mover (
        .clk        (clk),
        .rst        (rst),
        .aw_accept  (aw_accept),
        .burst_ch   (burst_ch),
        .buf_data   (buf_data),
        .buf_addr   (buf_addr),
        .axi_wdata  (axi_wdata),
        .axi_wvalid (axi_wvalid),
        .axi_wready (axi_wready),
        .axi_wlast  (axi_wlast),
        .burst_done (burst_done)
    );

endmodule

// ==== test/frame_wr_interconnect_asserts.sv ====
// valid/ready stability and pulse assertions and their binds to the address and data stages
module frame_wr_interconnect_asserts #(
    parameter int PAYLOAD_W = 256,
    parameter bit HAS_LAST  = 1'b1
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 valid,
    input logic                 ready,
    input logic [PAYLOAD_W-1:0] payload,
    input logic                 last,
    input logic                 pulse
);

    timeunit 1ns;
    timeprecision 1ps;

    // valid must hold through back-pressure
    a_valid_hold: assert property (@(posedge clk) disable iff (!rst)
        valid && !ready |=> valid)
        else $error("valid dropped before the handshake");

    a_payload_stable: assert property (@(posedge clk) disable iff (!rst)
        valid && !ready |=> $stable(payload))
        else $error("payload changed under back-pressure");

    a_pulse_single: assert property (@(posedge clk) disable iff (!rst)
        pulse |=> !pulse)
        else $error("stage pulse lasted more than one cycle");

    // only the data channel has a last flag
    if (HAS_LAST) begin : g_last
        a_last_stable: assert property (@(posedge clk) disable iff (!rst)
            valid && !ready |=> $stable(last))
            else $error("last flag changed under back-pressure");

        a_last_with_valid: assert property (@(posedge clk) disable iff (!rst)
            last |-> valid)
            else $error("last flag seen without valid");
    end

endmodule

bind wr_addr_gen frame_wr_interconnect_asserts #(
    .PAYLOAD_W (wr_ic_pkg::DDR_ADDR_W),
    .HAS_LAST  (1'b0)
) u_aw_asserts (
    .clk     (clk),
    .rst     (rst),
    .valid   (axi_awvalid),
    .ready   (axi_awready),
    .payload (axi_awaddr),
    .last    (1'b0),
    .pulse   (aw_accept)
);

bind wr_burst_mover frame_wr_interconnect_asserts #(
    .PAYLOAD_W (wr_ic_pkg::DATA_W),
    .HAS_LAST  (1'b1)
) u_w_asserts (
    .clk     (clk),
    .rst     (rst),
    .valid   (axi_wvalid),
    .ready   (axi_wready),
    .payload (axi_wdata),
    .last    (axi_wlast),
    .pulse   (burst_done)
);

// ==== test/tb_frame_wr_interconnect.sv ====
// testbench with clock, reset, random buffer and bus stimulus, reference model, compare tasks
module tb_frame_wr_interconnect
    import wr_ic_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES  = 10;
    localparam int NUM_BURSTS    = 80;
    localparam int BURST_TIMEOUT = 2000;   // cycles allowed per burst
    localparam int FE_START      = 300;    // frame ends start after this cycle

    logic      clk;
    logic      rst;
    logic      buf_ready [NUM_CH];
    axi_data_t buf_data  [NUM_CH];
    buf_addr_t buf_addr  [NUM_CH];
    logic      frame_end [NUM_CH];
    logic      init_done;
    ddr_addr_t axi_awaddr;
    logic      axi_awvalid;
    logic      axi_awready;
    axi_data_t axi_wdata;
    logic      axi_wvalid;
    logic      axi_wready;
    logic      axi_wlast;

    integer    seed;
    int        cycle;
    int        errors;
    int        checks;
    int        tests;
    int        fe_on_hs;
    logic      timed_out;
    string     test_name;
    axi_data_t data_table [NUM_CH][2**BUF_ADDR_W];
    logic      fe_last [NUM_CH];

    // reference model state
    ch_idx_t   m_ch;
    ch_idx_t   m_last_ch;
    logic      m_waiting;
    logic      m_start;                    // start expected at the next edge
    logic      m_done;                     // burst_done expected at the next edge
    int        m_offset [NUM_CH];
    logic      m_bank   [NUM_CH];
    buf_addr_t m_buf_addr [NUM_CH];
    logic      m_init;
    ddr_addr_t m_awaddr;
    logic      m_aw_pending;
    logic      m_in_burst;
    int        m_beat;
    int        bursts_done;

    frame_wr_interconnect DUT (
        .clk         (clk),
        .rst         (rst),
        .buf_ready   (buf_ready),
        .buf_data    (buf_data),
        .buf_addr    (buf_addr),
        .frame_end   (frame_end),
        .init_done   (init_done),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_wlast   (axi_wlast)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_addr(input string what, input ddr_addr_t exp, input ddr_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_data(input string what, input axi_data_t exp, input axi_data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_buf_addr(input string what, input buf_addr_t exp, input buf_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic fill_table();
        axi_data_t word;
        for (int c = 0; c < NUM_CH; c++) begin
            for (int a = 0; a < 2**BUF_ADDR_W; a++) begin
                for (int w = 0; w < DATA_W / 32; w++) begin
                    word[w*32 +: 32] = $random(seed);
                end
                data_table[c][a] = word;
            end
        end
    endtask

    task automatic drive_random();
        logic fe_enable;
        fe_enable = (cycle >= FE_START);
        for (int c = 0; c < NUM_CH; c++) begin
            fe_last[c]   = frame_end[c];
            buf_ready[c] = (($random(seed) & 3) != 0);
            frame_end[c] = fe_enable && !fe_last[c] && (($random(seed) & 63) == 0);
        end
        axi_awready = (($random(seed) & 7) < 4);
        axi_wready  = (($random(seed) & 7) < 6);
        // aim a frame end at the address handshake edge now and then
        if (fe_enable && axi_awvalid && axi_awready && !fe_last[m_ch]
                && (($random(seed) & 3) == 0)) begin
            frame_end[m_ch] = 1'b1;
        end
    endtask

    task automatic reset_model();
        m_ch         = '0;
        m_last_ch    = '0;
        m_waiting    = 1'b1;
        m_start      = 1'b0;
        m_done       = 1'b0;
        m_init       = 1'b0;
        m_aw_pending = 1'b0;
        m_in_burst   = 1'b0;
        m_beat       = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            m_offset[c]   = 0;
            m_bank[c]     = 1'b0;
            m_buf_addr[c] = '0;
        end
    endtask

    task automatic wait_for_burst(input int count, output logic ok);
        int cycles;
        cycles = 0;
        while (bursts_done < count && cycles < BURST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (bursts_done >= count);
    endtask

    task automatic report_test(input int err_mark);
        tests++;
        if (errors == err_mark) begin
            $display("%s: pass", test_name);
        end else begin
            $display("%s: fail with %0d errors", test_name, errors - err_mark);
        end
    endtask

    // zero latency buffers, inputs move on the falling edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle > RESET_CYCLES) begin
            drive_random();
        end
        for (int c = 0; c < NUM_CH; c++) begin
            buf_data[c] = data_table[c][buf_addr[c]];
        end
    end

    // reference model, runs on the values present at each rising edge
    always @(posedge clk) begin
        logic start_now;
        logic done_now;
        start_now = m_start;
        done_now  = m_done;
        m_start   = 1'b0;
        m_done    = 1'b0;
        if (!rst) begin
            reset_model();
        end else begin
            check_flag("init_done", m_init, init_done);
            if (start_now) begin   // address formed from pre-edge offset and bank
                m_awaddr = ddr_addr_t'(int'(m_ch) * CH_SPAN + (m_bank[m_ch] ? FRAME_SPAN : 0)
                                       + m_offset[m_ch]);
                m_aw_pending = 1'b1;
            end
            if (axi_awvalid && axi_awready) begin
                if (!m_aw_pending) begin
                    errors++;
                    $display("%s: address handshake seen with no burst address pending",
                             test_name);
                end else begin
                    check_addr("awaddr", m_awaddr, axi_awaddr);
                    check_addr("region", ddr_addr_t'(m_ch), ddr_addr_t'(axi_awaddr / CH_SPAN));
                    m_aw_pending = 1'b0;
                    m_in_burst   = 1'b1;
                    m_beat       = 0;
                    if (frame_end[m_ch]) begin
                        fe_on_hs++;
                    end else begin
                        m_offset[m_ch] = m_offset[m_ch] + ADDR_STEP;
                    end
                end
            end
            if (axi_wvalid && axi_wready) begin
                if (!m_in_burst) begin
                    errors++;
                    $display("%s: data beat accepted outside a burst", test_name);
                end else begin
                    check_data("wdata", data_table[m_ch][m_buf_addr[m_ch]], axi_wdata);
                    check_flag("wlast", m_beat == BURST_LEN - 1, axi_wlast);
                    m_buf_addr[m_ch] = m_buf_addr[m_ch] + 1'b1;
                    m_beat++;
                    if (m_beat == BURST_LEN) begin
                        m_in_burst = 1'b0;
                        m_done     = 1'b1;
                    end
                end
            end
            if (done_now) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    check_buf_addr($sformatf("buf_addr[%0d]", c), m_buf_addr[c], buf_addr[c]);
                end
                m_last_ch = m_ch;
                m_ch      = (m_ch == ch_idx_t'(NUM_CH - 1)) ? '0 : m_ch + 1'b1;
                m_waiting = 1'b1;
                bursts_done++;
            end else if (m_waiting && buf_ready[m_ch]) begin
                m_waiting = 1'b0;
                m_start   = 1'b1;
            end
            for (int c = 0; c < NUM_CH; c++) begin
                if (frame_end[c]) begin
                    m_offset[c] = 0;
                    m_bank[c]   = ~m_bank[c];
                end
            end
            if (frame_end[INIT_CH]) begin
                m_init = 1'b1;
            end
        end
    end

    initial begin : main_flow
        logic ok;
        int   err_mark;
        seed        = 32'h816b9fc5;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        fe_on_hs    = 0;
        bursts_done = 0;
        timed_out   = 1'b0;
        rst         = 1'b0;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        fill_table();
        reset_model();
        for (int c = 0; c < NUM_CH; c++) begin
            buf_ready[c] = 1'b0;
            frame_end[c] = 1'b0;
            fe_last[c]   = 1'b0;
            buf_data[c]  = data_table[c][0];
        end

        test_name = "reset_state";
        repeat (RESET_CYCLES) @(negedge clk);
        err_mark = errors;
        check_flag("axi_awvalid", 1'b0, axi_awvalid);
        check_flag("axi_wvalid", 1'b0, axi_wvalid);
        check_flag("axi_wlast", 1'b0, axi_wlast);
        check_flag("init_done", 1'b0, init_done);
        for (int c = 0; c < NUM_CH; c++) begin
            check_buf_addr($sformatf("buf_addr[%0d]", c), '0, buf_addr[c]);
        end
        rst = 1'b1;
        report_test(err_mark);

        ok = 1'b1;
        for (int k = 0; k < NUM_BURSTS && ok; k++) begin
            test_name = $sformatf("burst_%0d", k);
            err_mark  = errors;
            wait_for_burst(k + 1, ok);
            if (!ok) begin
                timed_out = 1'b1;
                $display("%s: timed out, the burst on channel %0d did not finish in %0d cycles",
                         test_name, m_ch, BURST_TIMEOUT);
            end else begin
                $display("%s ran on channel %0d", test_name, m_last_ch);
                report_test(err_mark);
            end
        end

        test_name = "init_flag";
        err_mark  = errors;
        check_flag("init_done", 1'b1, init_done);
        report_test(err_mark);

        $display("tests %0d, checks %0d, errors %0d, frame ends on address handshake %0d",
                 tests, checks, errors, fe_on_hs);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/wr_ic_pkg.sv
verilog/wr_channel_sched.sv
verilog/wr_addr_gen.sv
verilog/wr_burst_mover.sv
verilog/frame_wr_interconnect.sv
test/frame_wr_interconnect_asserts.sv
test/tb_frame_wr_interconnect.sv
